// File: common/smc_consts.svh
/*
  Width and offset constants for the static memory controller.
  Only one configuration register exists, at SMC_CFG_OFFSET.
  SMC_PADDR_W must stay wide enough to hold SMC_CFG_OFFSET.
*/
`ifndef SMC_CONSTS_SVH
`define SMC_CONSTS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SMC_DATA_W   32       // Host, APB and memory data
`define SMC_PADDR_W  5        // APB address, byte offsets 0x00..0x1f
`define SMC_MADDR_W  8        // Memory word address, 256 words

// ------------------------------
// Configuration register
// ------------------------------
`define SMC_WAIT_W   4        // One wait-state field, 0..15 extra cycles

// Single decoded register
`define SMC_CFG_OFFSET 5'h00

`endif

// File: common/smc_pkg.sv
/*
  Shared types for the static memory controller.
  Widths come from smc_consts.svh.
  smc_cfg_t holds only the 9 implemented bits, read-back zero-extends it.
*/
`include "smc_consts.svh"

package smc_pkg;

  typedef logic [`SMC_DATA_W-1:0]  smc_data_t;   // Data word
  typedef logic [`SMC_PADDR_W-1:0] smc_paddr_t;  // APB byte address
  typedef logic [`SMC_MADDR_W-1:0] smc_maddr_t;  // Memory word address
  typedef logic [`SMC_WAIT_W-1:0]  smc_wait_t;   // Wait-state count

  // Config register layout, MSB first: bit 8, bits 7:4, bits 3:0
  typedef struct packed {
    logic      enable;   // Accept host requests
    smc_wait_t wr_wait;  // Extra write strobe cycles
    smc_wait_t rd_wait;  // Extra read strobe cycles
  } smc_cfg_t;

  // Host request, one word
  typedef struct packed {
    smc_maddr_t addr;
    smc_data_t  wdata;
    logic       write;   // 1 = write, 0 = read
  } smc_req_t;

  // SRAM-style bus, strobes active low
  typedef struct packed {
    smc_maddr_t addr;
    smc_data_t  wdata;
    logic       cs_n;
    logic       oe_n;
    logic       we_n;
  } smc_mem_out_t;

  typedef enum logic [1:0] {SMC_IDLE, SMC_STROBE, SMC_DONE} smc_state_t;

endpackage

// File: smc_apb/smc_cfreg.sv
/*
  Configuration register, 9 bits, cleared by reset.
  Loads pwdata[8:0] on a selected write, upper bits ignored.
  Read-back is zero-extended and zero while unselected.
*/
`timescale 1ns/1ps

module smc_cfreg
  import smc_pkg::*;
(
  input  logic      pclk,
  input  logic      rst_n,
  input  logic      selreg,  // From address decode
  input  logic      pwrite,
  input  smc_data_t pwdata,
  output smc_data_t rdata,
  output smc_cfg_t  cfg
);

  localparam int CFG_W = $bits(smc_cfg_t);  // 9 implemented bits

  smc_cfg_t cfg_q;

  // ------------------------------
  // Register write
  // ------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      cfg_q <= '0;  // Controller disabled, zero waits
    end
    else if (selreg && pwrite)
    begin
      cfg_q <= smc_cfg_t'(pwdata[CFG_W-1:0]);
    end
  end

  // Upper bits read as zero
  always_comb
  begin
    rdata = '0;
    if (selreg)
    begin
      rdata[CFG_W-1:0] = cfg_q;
    end
  end

  assign cfg = cfg_q;  // To state machine and wait counter

endmodule

// File: smc_apb/smc_apb_if.sv
/*
  APB slave for the controller's single configuration register.
  No pready or pslverr: every access completes in its enable cycle.
  Offsets other than SMC_CFG_OFFSET read zero and drop writes.
*/
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_apb_if
  import smc_pkg::*;
(
  input  logic       pclk,
  input  logic       rst_n,
  input  logic       psel,     // APB select
  input  logic       penable,  // Access phase
  input  logic       pwrite,   // 1 = write
  input  smc_paddr_t paddr,
  input  smc_data_t  pwdata,
  output smc_data_t  prdata,
  output smc_cfg_t   cfg       // Live register contents
);

  logic      selreg;     // Config register selected in access phase
  smc_data_t cfg_rdata;  // Register read-back, zero when unselected

  // ------------------------------
  // Register select decode
  // ------------------------------
  always_comb
  begin
    selreg = 1'b0;
    if (psel && penable)
    begin
      selreg = (paddr == `SMC_CFG_OFFSET);  // Only one register decoded
    end
  end

  smc_cfreg u_cfreg (
    .pclk   (pclk),
    .rst_n  (rst_n),
    .selreg (selreg),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .rdata  (cfg_rdata),
    .cfg    (cfg)
  );

  // Read mux, only a selected read drives data
  assign prdata = (selreg && !pwrite) ? cfg_rdata : '0;

endmodule

// File: rtl/smc_state.sv
/*
  Access sequencer: SMC_IDLE -> SMC_STROBE -> SMC_DONE -> SMC_IDLE.
  Strobe phase length is set by the wait counter via wait_last.
  req_ready only in SMC_IDLE with cfg.enable set.
  done flags the done cycle of a read only; writes get no response.
*/
`timescale 1ns/1ps

module smc_state
  import smc_pkg::*;
(
  input  logic     pclk,
  input  logic     rst_n,
  input  smc_cfg_t cfg,
  input  logic     req_valid,
  input  logic     req_write,  // Direction of the offered request
  input  logic     wait_last,  // Final strobe cycle
  output logic     req_ready,
  output logic     accept,     // Request taken this edge
  output logic     in_strobe,
  output logic     done        // Read response cycle
);

  smc_state_t state_q;
  smc_state_t state_d;
  logic       acc_write_q;  // Direction of the access in flight

  // ------------------------------
  // Handshake
  // ------------------------------
  assign req_ready = (state_q == SMC_IDLE) && cfg.enable;
  assign accept    = req_ready && req_valid;  // Counter loads on this too

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_d = state_q;  // Hold by default
    case (state_q)
      SMC_IDLE:
      begin
        if (accept)
        begin
          state_d = SMC_STROBE;
        end
      end
      SMC_STROBE:
      begin
        if (wait_last)
        begin
          state_d = SMC_DONE;  // N+1 strobe cycles complete
        end
      end
      SMC_DONE:
      begin
        state_d = SMC_IDLE;  // Single turnaround cycle
      end
      default:
      begin
        state_d = SMC_IDLE;
      end
    endcase
  end

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      state_q     <= SMC_IDLE;
      acc_write_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        acc_write_q <= req_write;  // Held until next accept
      end
    end
  end

  assign in_strobe = (state_q == SMC_STROBE);
  assign done      = (state_q == SMC_DONE) && !acc_write_q;  // Reads only

endmodule

// File: rtl/smc_wait_counter.sv
/*
  Loadable down-counter for strobe wait states.
  Loads rd_wait or wr_wait at accept, so later config writes
  do not touch the access in flight. last marks the final strobe cycle.
*/
`timescale 1ns/1ps

module smc_wait_counter
  import smc_pkg::*;
(
  input  logic     pclk,
  input  logic     rst_n,
  input  logic     load,      // Accept cycle
  input  smc_cfg_t cfg,
  input  logic     write,     // Picks wr_wait over rd_wait
  input  logic     count_en,  // High through the strobe phase
  output logic     last
);

  smc_wait_t cnt_q;

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else if (load)
    begin
      cnt_q <= write ? cfg.wr_wait : cfg.rd_wait;
    end
    else if (count_en && (cnt_q != '0))
    begin
      cnt_q <= cnt_q - 1'b1;  // Stops at zero
    end
  end

  assign last = count_en && (cnt_q == '0);  // N waits -> N+1 strobe cycles

endmodule

// File: rtl/smc_data_path.sv
/*
  Request capture and SRAM bus drive.
  Address and write data hold from accept to the next accept.
  Read data is sampled every read strobe cycle, last sample kept.
  mem_rdata is assumed valid by the end of the final strobe cycle.
*/
`timescale 1ns/1ps

module smc_data_path
  import smc_pkg::*;
(
  input  logic         pclk,
  input  logic         rst_n,
  input  logic         accept,
  input  smc_req_t     req,
  input  logic         in_strobe,
  input  logic         done,       // Read done cycle from the FSM
  output smc_mem_out_t mem_out,
  input  smc_data_t    mem_rdata,
  output logic         rsp_valid,
  output smc_data_t    rsp_rdata
);

  smc_req_t  req_q;    // Latched request, direction included
  smc_data_t rdata_q;

  // ------------------------------
  // Request and read capture
  // ------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      req_q <= '0;
    end
    else if (accept)
    begin
      req_q <= req;
    end
  end

  always_ff @(posedge pclk)
  begin
    if (in_strobe && !req_q.write)
    begin
      rdata_q <= mem_rdata;  // Overwritten until strobe ends
    end
  end

  // Bus drive
  assign mem_out.addr  = req_q.addr;
  assign mem_out.wdata = req_q.wdata;
  assign mem_out.cs_n  = !in_strobe;
  assign mem_out.oe_n  = !(in_strobe && !req_q.write);
  assign mem_out.we_n  = !(in_strobe && req_q.write);

  assign rsp_valid = done;     // One cycle, no back-pressure
  assign rsp_rdata = rdata_q;

endmodule

// File: rtl/smc_top.sv
/*
  Static memory controller top level.
  APB config port, single-word host port, async SRAM-style bus.
  Host must not be stalled on rsp_valid; there is no response ready.
*/
`timescale 1ns/1ps

module smc_top
  import smc_pkg::*;
(
  input  logic         pclk,
  input  logic         rst_n,
  // APB
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  smc_paddr_t   paddr,
  input  smc_data_t    pwdata,
  output smc_data_t    prdata,
  // Host
  input  logic         req_valid,
  input  smc_req_t     req,
  output logic         req_ready,
  output logic         rsp_valid,
  output smc_data_t    rsp_rdata,
  // Memory
  output smc_mem_out_t mem_out,
  input  smc_data_t    mem_rdata
);

  smc_cfg_t cfg;
  logic     accept;
  logic     in_strobe;
  logic     done;
  logic     wait_last;

  // ------------------------------
  // Config and control
  // ------------------------------
  smc_apb_if u_apb_if (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .cfg     (cfg)
  );

  smc_state u_state (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .req_valid (req_valid),
    .req_write (req.write),
    .wait_last (wait_last),
    .req_ready (req_ready),
    .accept    (accept),
    .in_strobe (in_strobe),
    .done      (done)
  );

  smc_wait_counter u_wait_counter (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .load     (accept),
    .cfg      (cfg),
    .write    (req.write),  // Sampled with load
    .count_en (in_strobe),
    .last     (wait_last)
  );

  // Memory side
  smc_data_path u_data_path (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .accept    (accept),
    .req       (req),
    .in_strobe (in_strobe),
    .done      (done),
    .mem_out   (mem_out),
    .mem_rdata (mem_rdata),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata)
  );

endmodule

// File: dv/smc_sram_model.sv
/*
  Behavioral asynchronous SRAM for the controller's memory bus.
  Cleared to zero at time 0. Writes while cs_n and we_n are low.
  Read data is combinational and X while the output is not enabled.
*/
`timescale 1ns/1ps

module smc_sram_model
  import smc_pkg::*;
(
  input  smc_mem_out_t mem_out,
  output smc_data_t    mem_rdata
);

  localparam int DEPTH = 1 << $bits(smc_maddr_t);  // One word per address

  smc_data_t mem [0:DEPTH-1];

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      mem[i] = '0;  // Unwritten words read zero
    end
  end

  // Level-sensitive write, last value during the strobe wins
  always @(mem_out)
  begin
    if (!mem_out.cs_n && !mem_out.we_n)
    begin
      mem[mem_out.addr] = mem_out.wdata;
    end
  end

  assign mem_rdata = (!mem_out.cs_n && !mem_out.oe_n) ? mem[mem_out.addr] : 'x;

endmodule

// File: dv/smc_tb.sv
/*
  Testbench for the static memory controller.
  Random stimulus from seed 26, checked against a model in the testbench.
  Inputs change 2 ns after pclk rises, outputs are sampled 1 ns after it.
  Host addresses stay within 32 words so reads hit earlier writes.
*/
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_tb
  import smc_pkg::*;
();

  localparam int NUM_ACC     = 64;
  localparam int TIMEOUT_CYC = 50 + NUM_ACC * 20;  // Longest access times access count

  logic         pclk;
  logic         rst_n;
  logic         psel;
  logic         penable;
  logic         pwrite;
  smc_paddr_t   paddr;
  smc_data_t    pwdata;
  smc_data_t    prdata;
  logic         req_valid;
  smc_req_t     req;
  logic         req_ready;
  logic         rsp_valid;
  smc_data_t    rsp_rdata;
  smc_mem_out_t mem_out;
  smc_data_t    mem_rdata;

  integer    seed;
  int        errors;
  int        data_errors;    // Read data mismatches
  int        timing_errors;  // Strobe width and latency mismatches
  int        tests_run;
  int        tests_failed;
  int        cycle_count;
  smc_cfg_t  model_cfg;       // Model of the config register
  smc_data_t model_mem [int]; // Written words only

  smc_top dut (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .mem_out   (mem_out),
    .mem_rdata (mem_rdata)
  );

  smc_sram_model u_sram (
    .mem_out   (mem_out),
    .mem_rdata (mem_rdata)
  );

  // ------------------------------
  // Clock and watchdog
  // ------------------------------
  initial
  begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;  // 40 ns period
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYC)
    begin
      @(posedge pclk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Errors found");
    $finish;
  end

  // ------------------------------
  // Reporting helpers
  // ------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic finish_test(input string name, input int test_errors);
    tests_run++;
    if (test_errors == 0)
      $display("Test %s: passed", name);
    else
    begin
      $display("Test %s: failed with %0d mismatches", name, test_errors);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // APB tasks, entered and left at the drive point
  // ------------------------------
  task automatic apb_write(input smc_paddr_t addr, input smc_data_t data);
    psel   = 1'b1;  // Setup phase
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge pclk);
    #2 penable = 1'b1;  // Access phase, register loads on next edge
    @(posedge pclk);
    #2 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input smc_paddr_t addr, output smc_data_t data);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge pclk);
    #2 penable = 1'b1;
    @(posedge pclk);
    #1 data = prdata;  // Still in the access phase
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic program_cfg(input smc_cfg_t cfg);
    apb_write(`SMC_CFG_OFFSET, smc_data_t'(cfg));
    model_cfg = cfg;
  endtask

  // ------------------------------
  // Host access with timing checks
  // ------------------------------
  task automatic host_access(input logic write, input smc_maddr_t addr,
                             input smc_data_t wdata);
    int        n;
    int        cyc;
    int        strobe_cycles;
    int        rsp_cycle;
    int        wait_cyc;
    smc_data_t exp;
    smc_data_t got;
    n   = write ? model_cfg.wr_wait : model_cfg.rd_wait;  // Fixed at accept
    exp = model_mem.exists(int'(addr)) ? model_mem[int'(addr)] : '0;
    req_valid  = 1'b1;
    req.write  = write;
    req.addr   = addr;
    req.wdata  = wdata;
    wait_cyc   = 0;
    while (!req_ready && wait_cyc < 8)
    begin
      @(posedge pclk);
      #2 wait_cyc++;
    end
    if (!req_ready)
    begin
      $display("Controller never raised req_ready for the access to %h", addr);
      errors++;
      req_valid = 1'b0;
      return;
    end
    @(posedge pclk);  // Accept edge, cycle 0
    #1;
    cyc           = 0;
    strobe_cycles = 0;
    rsp_cycle     = -1;
    got           = '0;
    do
    begin
      cyc++;  // Bus state up to the next edge
      if (!mem_out.cs_n)
      begin
        strobe_cycles++;
        if (mem_out.oe_n !== write)
          report_mismatch("mem_out.oe_n", write, mem_out.oe_n);
        if (mem_out.we_n !== !write)
          report_mismatch("mem_out.we_n", !write, mem_out.we_n);
        if (mem_out.addr !== addr)
          report_mismatch("mem_out.addr", addr, mem_out.addr);
        if (write && mem_out.wdata !== wdata)
          report_mismatch("mem_out.wdata", wdata, mem_out.wdata);
      end
      if (rsp_valid)
      begin
        rsp_cycle = cyc;
        got       = rsp_rdata;
      end
      #1 req_valid = 1'b0;
      @(posedge pclk);
      #1;
    end
    while (!req_ready && cyc < 24);
    #1;  // Back to the drive point
    if (!req_ready)
    begin
      $display("Access to %h did not return to idle within 24 cycles", addr);
      errors++;
      timing_errors++;
    end
    if (strobe_cycles != n + 1)
    begin
      report_mismatch("cs_n low cycles", n + 1, strobe_cycles);
      timing_errors++;
    end
    if (write)
    begin
      model_mem[int'(addr)] = wdata;
      if (rsp_cycle != -1)
      begin
        $display("rsp_valid pulsed for the write to %h", addr);
        errors++;
        timing_errors++;
      end
    end
    else
    begin
      if (rsp_cycle != n + 2)
      begin
        report_mismatch("rsp_valid latency", n + 2, rsp_cycle);
        timing_errors++;
      end
      if (got !== exp)
      begin
        report_mismatch("rsp_rdata", exp, got);
        data_errors++;
      end
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin : main_seq
    int         err_before;
    smc_data_t  rd;
    smc_data_t  wd;
    smc_paddr_t off;
    logic       wr;
    smc_maddr_t addr;
    seed          = 26;
    errors        = 0;
    data_errors   = 0;
    timing_errors = 0;
    tests_run     = 0;
    tests_failed  = 0;
    model_cfg     = '0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req_valid = 1'b0;
    req       = '0;
    repeat (4) @(posedge pclk);
    #2 rst_n = 1'b1;

    // Reset state
    err_before = errors;
    if (mem_out.cs_n !== 1'b1)
      report_mismatch("mem_out.cs_n", 1, mem_out.cs_n);
    if (mem_out.oe_n !== 1'b1)
      report_mismatch("mem_out.oe_n", 1, mem_out.oe_n);
    if (mem_out.we_n !== 1'b1)
      report_mismatch("mem_out.we_n", 1, mem_out.we_n);
    if (req_ready !== 1'b0)
      report_mismatch("req_ready", 0, req_ready);
    if (rsp_valid !== 1'b0)
      report_mismatch("rsp_valid", 0, rsp_valid);
    if (prdata !== '0)
      report_mismatch("prdata", 0, prdata);
    apb_read(`SMC_CFG_OFFSET, rd);
    if (rd !== '0)
      report_mismatch("prdata", 0, rd);
    finish_test("reset state", errors - err_before);

    // Register access, only bits 8:0 stored
    err_before = errors;
    repeat (10)
    begin
      wd = $random(seed);
      apb_write(`SMC_CFG_OFFSET, wd);
      model_cfg = smc_cfg_t'(wd[8:0]);
      apb_read(`SMC_CFG_OFFSET, rd);
      if (rd !== (wd & 32'h1ff))
        report_mismatch("prdata", wd & 32'h1ff, rd);
    end
    repeat (4)
    begin
      off = $random(seed);
      if (off == `SMC_CFG_OFFSET)
        off = 5'h04;
      apb_read(off, rd);
      if (rd !== '0)
        report_mismatch("prdata", 0, rd);
      wd = $random(seed);
      apb_write(off, wd);  // Must be dropped
      apb_read(`SMC_CFG_OFFSET, rd);
      if (rd !== smc_data_t'(model_cfg))
        report_mismatch("prdata", smc_data_t'(model_cfg), rd);
    end
    finish_test("register access", errors - err_before);

    // Disabled controller ignores requests
    err_before = errors;
    wd = $random(seed);
    program_cfg(smc_cfg_t'({1'b0, wd[7:0]}));
    req_valid = 1'b1;
    req       = '0;
    repeat (10)
    begin
      @(posedge pclk);
      #1;
      if (req_ready !== 1'b0)
        report_mismatch("req_ready", 0, req_ready);
      if (mem_out.cs_n !== 1'b1)
        report_mismatch("mem_out.cs_n", 1, mem_out.cs_n);
      #1;
    end
    req_valid = 1'b0;
    finish_test("disabled controller", errors - err_before);

    // Random accesses, new wait fields every 8 accesses
    for (int i = 0; i < NUM_ACC; i++)
    begin
      if (i % 8 == 0)
      begin
        wd = $random(seed);
        program_cfg(smc_cfg_t'({1'b1, wd[7:0]}));
      end
      wr   = $random(seed);
      addr = $random(seed) & 8'h1f;
      wd   = $random(seed);
      host_access(wr, addr, wd);
    end
    finish_test("data integrity", data_errors);
    finish_test("strobe and latency timing", timing_errors);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/smc_pkg.sv
smc_apb/smc_cfreg.sv
smc_apb/smc_apb_if.sv
rtl/smc_state.sv
rtl/smc_wait_counter.sv
rtl/smc_data_path.sv
rtl/smc_top.sv
dv/smc_sram_model.sv
dv/smc_tb.sv

// File: Bender.yml
package:
  name: smc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/smc_pkg.sv
      - smc_apb/smc_cfreg.sv
      - smc_apb/smc_apb_if.sv
      - rtl/smc_state.sv
      - rtl/smc_wait_counter.sv
      - rtl/smc_data_path.sv
      - rtl/smc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/smc_sram_model.sv
      - dv/smc_tb.sv
